// ==== verilog/icmp_pkg.sv ====
/*
  shared definitions for the icmp echo responder
  - vector types for stream bytes, lengths, checksums and addresses
  - icmp type codes, header size and payload buffer sizing
  - receive parser state encoding
*/
`default_nettype none

package icmp_pkg;

  // ------------------------------
  // vector types
  // ------------------------------
  // one byte of the rx or tx stream
  typedef logic [7:0]  byte_t;
  // message length in bytes, header included
  typedef logic [15:0] len_t;
  typedef logic [15:0] csum_t;
  // running sum, wide enough to keep the carries of 64 payload bytes
  typedef logic [31:0] sum_t;
  typedef logic [47:0] mac_t;
  typedef logic [31:0] ip_t;

  // ------------------------------
  // icmp constants
  // ------------------------------
  localparam byte_t ICMP_ECHO_REQUEST    = 8'd8;
  localparam byte_t ICMP_DST_UNREACHABLE = 8'd3;
  // type, code and two checksum bytes
  localparam len_t  HEADER_LEN           = 16'd4;

  // payload storage, one message at a time
  localparam int PAYLOAD_DEPTH = 64;
  localparam int PTR_W         = 6;

  // receive parser states
  typedef enum logic [2:0] {
    idle,
    header,
    payload,
    request,
    sending,
    discard,
    unreachable
  } parser_state_t;

endpackage

`default_nettype wire

// ==== verilog/payload_fifo_if.sv ====
/*
  payload storage link
  - parser writes and clears, buffer stores, framer reads
*/
`default_nettype none

interface payload_fifo_if import icmp_pkg::*; ();

  // write side, owned by the parser
  logic  clear;
  logic  wr_en;
  byte_t wr_data;
  logic  full;

  // read side, show-ahead
  logic  rd_en;
  byte_t rd_data;
  logic  empty;

  modport writer (output clear, output wr_en, output wr_data, input full);

  modport store (input clear, input wr_en, input wr_data, input rd_en,
                 output full, output rd_data, output empty);

  modport reader (output rd_en, input rd_data, input empty);

endinterface

`default_nettype wire

// ==== verilog/echo_reply_if.sv ====
/*
  reply request link between parser and framer
  - request flag with the reply length and checksum
  - busy flag back from the framer
*/
`default_nettype none

interface echo_reply_if import icmp_pkg::*; ();

  // held by the parser until busy is seen
  logic  req;
  len_t  reply_len;
  csum_t reply_csum;

  // high for the whole tx burst
  logic  busy;

  modport requester (output req, output reply_len, output reply_csum, input busy);

  modport sender (input req, input reply_len, input reply_csum, output busy);

endinterface

`default_nettype wire

// ==== verilog/icmp_rx_parser.sv ====
/*
  icmp receive side
  - message state machine and header check
  - payload write and one's-complement accumulation
  - reply request with folded checksum, address latch
  - destination unreachable flag
*/
`default_nettype none

module icmp_rx_parser import icmp_pkg::*; (
  input  wire logic       rx_clock,
  input  wire logic       arst_n,
  input  wire logic       rx_enable,
  input  wire byte_t      rx_data,
  input  wire mac_t       remote_mac,
  input  wire ip_t        remote_ip,
  output logic            dst_unreachable,
  output mac_t            destination_mac,
  output ip_t             destination_ip,
  payload_fifo_if.writer  fifo,
  echo_reply_if.requester reply
);

  parser_state_t state;
  logic          rx_enable_q;
  logic          start;
  // header byte index after the type byte
  logic [1:0]    hdr_cnt;
  len_t          len;
  sum_t          sum;

  // fold carries back in twice and complement
  function automatic csum_t fold_csum(input sum_t s);
    sum_t f;
    f = {16'd0, s[31:16]} + {16'd0, s[15:0]};
    f = {16'd0, f[31:16]} + {16'd0, f[15:0]};
    return ~f[15:0];
  endfunction

  // a message starts only on a rising rx_enable
  assign start = rx_enable && !rx_enable_q;

  // ------------------------------
  // state machine
  // ------------------------------
  always_ff @(posedge rx_clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state           <= idle;
      rx_enable_q     <= 1'b0;
      hdr_cnt         <= 2'd0;
      len             <= HEADER_LEN;
      sum             <= '0;
      dst_unreachable <= 1'b0;
    end
    else
    begin
      rx_enable_q     <= rx_enable;
      // flag is a single pulse
      dst_unreachable <= 1'b0;
      case (state)
        idle:
          if (start)
          begin
            hdr_cnt <= 2'd0;
            len     <= HEADER_LEN;
            sum     <= '0;
            // first byte is the icmp type
            if (rx_data == ICMP_ECHO_REQUEST)
              state <= header;
            else if (rx_data == ICMP_DST_UNREACHABLE)
              state <= unreachable;
            else
              state <= discard;
          end
        header:
          // message cut short so it is dropped
          if (!rx_enable)
            state <= idle;
          // code must be zero for an echo request
          else if (hdr_cnt == 2'd0 && rx_data != 8'd0)
            state <= discard;
          // checksum low byte ends the header
          else if (hdr_cnt == 2'd2)
            state <= payload;
          else
            hdr_cnt <= hdr_cnt + 2'd1;
        payload:
          if (!rx_enable)
            state <= request;
          // no room for this byte so no reply
          else if (fifo.full)
            state <= discard;
          else
          begin
            // even offset is the high byte of a 16-bit word
            sum <= sum + (len[0] ? {24'd0, rx_data} : {16'd0, rx_data, 8'd0});
            len <= len + 16'd1;
          end
        // hold the request until the framer takes it
        request:
          if (reply.busy)
            state <= sending;
        sending:
          if (!reply.busy)
            state <= idle;
        // skip the rest of the message
        discard:
          if (!rx_enable)
            state <= idle;
        unreachable:
        begin
          dst_unreachable <= 1'b1;
          state           <= discard;
        end
        default:
          state <= idle;
      endcase
    end
  end

  // reply goes back to whoever sent this message
  always_ff @(posedge rx_clock)
  begin
    if (state == idle && start)
    begin
      destination_mac <= remote_mac;
      destination_ip  <= remote_ip;
    end
  end

  // ------------------------------
  // buffer and reply links
  // ------------------------------
  assign fifo.clear   = (state == idle);
  assign fifo.wr_en   = (state == payload) && rx_enable && !fifo.full;
  assign fifo.wr_data = rx_data;

  assign reply.req        = (state == request);
  assign reply.reply_len  = len;
  assign reply.reply_csum = fold_csum(sum);

  // a new request never meets a busy framer and always fits the buffer
  a_req_valid: assert property (
    @(posedge rx_clock) disable iff (!arst_n)
    $rose(reply.req) |-> !reply.busy &&
                         reply.reply_len <= HEADER_LEN + len_t'(PAYLOAD_DEPTH)
  );

  // unreachable flag is one cycle wide
  a_unreach_pulse: assert property (
    @(posedge rx_clock) disable iff (!arst_n)
    dst_unreachable |=> !dst_unreachable
  );

endmodule

`default_nettype wire

// ==== verilog/payload_buffer.sv ====
/*
  payload byte FIFO
  - show-ahead read, full and empty flags
  - synchronous clear of the pointers
*/
`default_nettype none

module payload_buffer import icmp_pkg::*; (
  input  wire logic     rx_clock,
  input  wire logic     arst_n,
  payload_fifo_if.store fifo
);

  byte_t            mem [PAYLOAD_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = fifo.wr_en && !fifo.full;
  assign do_rd = fifo.rd_en && !fifo.empty;

  // pointers and fill level
  always_ff @(posedge rx_clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (fifo.clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leaves the level alone
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge rx_clock)
  begin
    if (do_wr && !fifo.clear)
      mem[wr_ptr] <= fifo.wr_data;
  end

  // head byte shown without latency
  assign fifo.rd_data = mem[rd_ptr];
  assign fifo.full    = (count == (PTR_W+1)'(PAYLOAD_DEPTH));
  assign fifo.empty   = (count == '0);

  a_no_write_full: assert property (
    @(posedge rx_clock) disable iff (!arst_n)
    fifo.wr_en |-> !fifo.full
  );

  a_no_read_empty: assert property (
    @(posedge rx_clock) disable iff (!arst_n)
    fifo.rd_en |-> !fifo.empty
  );

endmodule

`default_nettype wire

// ==== verilog/echo_tx_framer.sv ====
/*
  echo reply transmit side
  - grant on tx_enable, byte counter over the reply length
  - type, code and checksum bytes, then payload from the buffer
*/
`default_nettype none

module echo_tx_framer import icmp_pkg::*; (
  input  wire logic      rx_clock,
  input  wire logic      arst_n,
  input  wire logic      tx_enable,
  output logic           tx_active,
  output byte_t          tx_data,
  payload_fifo_if.reader fifo,
  echo_reply_if.sender   reply
);

  logic  busy;
  logic  grant;
  // index of the byte on tx_data
  len_t  count;
  len_t  len_q;
  csum_t csum_q;

  // the transmitter grants only while a request is up
  assign grant = tx_enable && reply.req && !busy;

  // ------------------------------
  // burst control
  // ------------------------------
  always_ff @(posedge rx_clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy  <= 1'b0;
      count <= '0;
    end
    else if (grant)
    begin
      busy  <= 1'b1;
      count <= '0;
    end
    else if (busy)
    begin
      // last byte goes out this cycle
      if (count == len_q - 16'd1)
        busy <= 1'b0;
      count <= count + 16'd1;
    end
  end

  // snapshot of the request, parser is free to move on
  always_ff @(posedge rx_clock)
  begin
    if (grant)
    begin
      len_q  <= reply.reply_len;
      csum_q <= reply.reply_csum;
    end
  end

  // ------------------------------
  // byte select
  // ------------------------------
  always_comb
  begin
    tx_data = '0;
    if (busy)
    begin
      case (count)
        // echo reply type and code are both zero
        16'd0:   tx_data = 8'd0;
        16'd1:   tx_data = 8'd0;
        16'd2:   tx_data = csum_q[15:8];
        16'd3:   tx_data = csum_q[7:0];
        default: tx_data = fifo.rd_data;
      endcase
    end
  end

  // pop each payload byte as it leaves
  assign fifo.rd_en = busy && (count >= HEADER_LEN);

  assign tx_active  = busy;
  assign reply.busy = busy;

  // the buffer always holds the whole payload of the reply
  a_payload_ready: assert property (
    @(posedge rx_clock) disable iff (!arst_n)
    busy && count >= HEADER_LEN |-> !fifo.empty
  );

endmodule

`default_nettype wire

// ==== verilog/icmp_echo_top.sv ====
/*
  icmp echo responder top
  - parser, payload buffer and tx framer on plain ports
*/
`default_nettype none

module icmp_echo_top import icmp_pkg::*; (
  input  wire logic  rx_clock,
  input  wire logic  arst_n,
  input  wire logic  rx_enable,
  input  wire byte_t rx_data,
  input  wire logic  tx_enable,
  input  wire mac_t  remote_mac,
  input  wire ip_t   remote_ip,
  output logic       dst_unreachable,
  output logic       tx_request,
  output logic       tx_active,
  output byte_t      tx_data,
  output len_t       length,
  output mac_t       destination_mac,
  output ip_t        destination_ip
);

  payload_fifo_if fifo_if ();
  echo_reply_if   reply_if ();

  // receive, check and request
  icmp_rx_parser parser0 (
    .rx_clock        (rx_clock),
    .arst_n          (arst_n),
    .rx_enable       (rx_enable),
    .rx_data         (rx_data),
    .remote_mac      (remote_mac),
    .remote_ip       (remote_ip),
    .dst_unreachable (dst_unreachable),
    .destination_mac (destination_mac),
    .destination_ip  (destination_ip),
    .fifo            (fifo_if.writer),
    .reply           (reply_if.requester)
  );

  payload_buffer buffer0 (
    .rx_clock (rx_clock),
    .arst_n   (arst_n),
    .fifo     (fifo_if.store)
  );

  // reply burst toward the transmitter
  echo_tx_framer framer0 (
    .rx_clock  (rx_clock),
    .arst_n    (arst_n),
    .tx_enable (tx_enable),
    .tx_active (tx_active),
    .tx_data   (tx_data),
    .fifo      (fifo_if.reader),
    .reply     (reply_if.sender)
  );

  assign tx_request = reply_if.req;
  assign length     = reply_if.reply_len;

endmodule

`default_nettype wire

// ==== verif/icmp_echo_checker.sv ====
/*
  reply checker for the icmp echo responder
  - captures each input message and builds the expected reply
  - compares burst bytes, length, addresses and the unreachable flag
  - error, message and reply counters
*/
`default_nettype none

module icmp_echo_checker import icmp_pkg::*; (
  input  wire logic  rx_clock,
  input  wire logic  arst_n,
  input  wire logic  rx_enable,
  input  wire byte_t rx_data,
  input  wire logic  tx_enable,
  input  wire mac_t  remote_mac,
  input  wire ip_t   remote_ip,
  input  wire logic  dst_unreachable,
  input  wire logic  tx_request,
  input  wire logic  tx_active,
  input  wire byte_t tx_data,
  input  wire len_t  length,
  input  wire mac_t  destination_mac,
  input  wire ip_t   destination_ip,
  output int         errors,
  output int         messages,
  output int         replies,
  output logic       reply_pending
);

  timeunit 1ns;
  timeprecision 1ps;

  int    error_count = 0;
  int    message_count = 0;
  int    reply_count = 0;
  // message being received and the reply it should produce
  byte_t msg_buf [128];
  int    msg_len;
  mac_t  msg_mac;
  ip_t   msg_ip;
  byte_t exp_buf [128];
  int    exp_len;
  mac_t  exp_mac;
  ip_t   exp_ip;
  // bytes seen on tx_data in the current burst
  byte_t burst [128];
  int    burst_len;
  logic  rx_enable_q;
  logic  tx_active_q;
  logic  tx_request_q;
  logic  grant_q;
  logic  exp_unreach;
  int    cycle;
  int    unreach_cycle;

  assign errors   = error_count;
  assign messages = message_count;
  assign replies  = reply_count;

  // one's-complement sum of big-endian words over data[first..last-1]
  function automatic logic [15:0] ones_sum(input byte_t data [128], input int first,
                                           input int last);
    logic [16:0] acc;
    logic [15:0] sum16;
    logic [15:0] word;
    sum16 = 16'd0;
    for (int k = first; k < last; k += 2)
    begin
      // odd tail byte gets a zero low byte
      word  = {data[k], (k + 1 < last) ? data[k + 1] : 8'd0};
      acc   = {1'b0, sum16} + {1'b0, word};
      sum16 = acc[15:0] + {15'd0, acc[16]};
    end
    return sum16;
  endfunction

  // reply bytes for a captured message, returns 0 when no reply is due
  function automatic bit expected_reply(input byte_t msg [128], input int n,
                                        output byte_t reply [128], output int reply_len);
    logic [15:0] csum;
    // payload sits at the same offsets in the reply
    reply     = msg;
    reply_len = 0;
    if (n < int'(HEADER_LEN) || msg[0] != ICMP_ECHO_REQUEST || msg[1] != 8'd0)
      return 1'b0;
    if (n - int'(HEADER_LEN) > PAYLOAD_DEPTH)
      return 1'b0;
    csum      = ~ones_sum(msg, int'(HEADER_LEN), n);
    reply[0]  = 8'd0;
    reply[1]  = 8'd0;
    reply[2]  = csum[15:8];
    reply[3]  = csum[7:0];
    reply_len = n;
    return 1'b1;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] got);
    $display("FAILED %s expected %0h got %0h at cycle %0d", name, expected, got, cycle);
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("error at cycle %0d: %s", cycle, what);
    error_count++;
  endtask

  // ------------------------------
  // compare on the falling edge
  // ------------------------------
  always @(negedge rx_clock)
  begin
    if (!arst_n)
    begin
      if (tx_request || tx_active || dst_unreachable || tx_data !== 8'd0)
        report_problem("outputs are not idle while reset is held");
      rx_enable_q   = 1'b0;
      tx_active_q   = 1'b0;
      tx_request_q  = 1'b0;
      grant_q       = 1'b0;
      reply_pending = 1'b0;
      msg_len       = 0;
      exp_len       = 0;
      burst_len     = 0;
      cycle         = 0;
      unreach_cycle = -1;
    end
    else
    begin
      cycle++;
      // message start, addresses as the dut latches them
      if (rx_enable && !rx_enable_q)
      begin
        msg_len = 0;
        msg_mac = remote_mac;
        msg_ip  = remote_ip;
        message_count++;
        if (rx_data == ICMP_DST_UNREACHABLE)
          unreach_cycle = cycle + 2;
      end
      if (rx_enable && msg_len < 128)
      begin
        msg_buf[msg_len] = rx_data;
        msg_len++;
      end
      // end of message decides whether a reply is owed
      if (!rx_enable && rx_enable_q)
      begin
        if (expected_reply(msg_buf, msg_len, exp_buf, exp_len))
        begin
          if (reply_pending)
            report_problem("new echo request ended before the last reply was sent");
          reply_pending = 1'b1;
          exp_mac       = msg_mac;
          exp_ip        = msg_ip;
        end
      end

      exp_unreach = (cycle == unreach_cycle);
      if (dst_unreachable !== exp_unreach)
        report_mismatch("dst_unreachable", 64'(exp_unreach), 64'(dst_unreachable));
      if (tx_request && !tx_request_q && !reply_pending)
        report_problem("tx_request raised without a valid echo request");

      // burst start must follow the grant by one cycle
      if (grant_q && !tx_active)
        report_problem("no tx_active one cycle after the tx_enable grant");
      if (tx_active && !tx_active_q)
      begin
        if (!reply_pending)
          report_problem("tx_active burst with no reply expected");
        if (!grant_q)
          report_problem("tx_active burst started without a grant on the cycle before");
        burst_len = 0;
        if (length !== 16'(exp_len))
          report_mismatch("length", 64'(exp_len), 64'(length));
        if (destination_mac !== exp_mac)
          report_mismatch("destination_mac", 64'(exp_mac), 64'(destination_mac));
        if (destination_ip !== exp_ip)
          report_mismatch("destination_ip", 64'(exp_ip), 64'(destination_ip));
      end
      if (tx_active && burst_len < 128)
      begin
        if (burst_len < exp_len && tx_data !== exp_buf[burst_len])
          report_mismatch($sformatf("tx_data[%0d]", burst_len), 64'(exp_buf[burst_len]),
                          64'(tx_data));
        if (burst_len == 1 && tx_request)
          report_problem("tx_request still high after the burst started");
        burst[burst_len] = tx_data;
        burst_len++;
      end
      // burst end, length and checksum of the whole reply
      if (!tx_active && tx_active_q)
      begin
        if (burst_len != exp_len)
          report_mismatch("tx_active burst length", 64'(exp_len), 64'(burst_len));
        if (ones_sum(burst, 0, burst_len) != 16'hffff)
          report_mismatch("reply word sum", 64'h0ffff, 64'(ones_sum(burst, 0, burst_len)));
        reply_count++;
        reply_pending = 1'b0;
      end

      grant_q      = tx_enable && tx_request && !tx_active;
      rx_enable_q  = rx_enable;
      tx_active_q  = tx_active;
      tx_request_q = tx_request;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_icmp_echo.sv ====
/*
  testbench for the icmp echo responder
  - clock, reset, random and directed icmp messages
  - transmitter model granting after a random delay
  - cycle limit and end-of-run summary
*/
`default_nettype none

module tb_icmp_echo import icmp_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RANDOM_MESSAGES   = 40;
  localparam int DIRECTED_MESSAGES = 9;
  localparam int MAX_PAYLOAD       = 70;
  // header, longest payload, longest reply, gap and grant delay
  localparam int MESSAGE_CYCLES    = 4 + MAX_PAYLOAD + (4 + MAX_PAYLOAD) + 10 + 7;
  localparam int TIMEOUT_CYCLES    = (RANDOM_MESSAGES + DIRECTED_MESSAGES) * MESSAGE_CYCLES + 500;

  logic  rx_clock;
  logic  arst_n;
  logic  rx_enable;
  byte_t rx_data;
  logic  tx_enable;
  mac_t  remote_mac;
  ip_t   remote_ip;
  logic  dst_unreachable;
  logic  tx_request;
  logic  tx_active;
  byte_t tx_data;
  len_t  length;
  mac_t  destination_mac;
  ip_t   destination_ip;
  int    check_errors;
  int    message_count;
  int    reply_count;
  logic  reply_pending;

  icmp_echo_top dut0 (
    .rx_clock        (rx_clock),
    .arst_n          (arst_n),
    .rx_enable       (rx_enable),
    .rx_data         (rx_data),
    .tx_enable       (tx_enable),
    .remote_mac      (remote_mac),
    .remote_ip       (remote_ip),
    .dst_unreachable (dst_unreachable),
    .tx_request      (tx_request),
    .tx_active       (tx_active),
    .tx_data         (tx_data),
    .length          (length),
    .destination_mac (destination_mac),
    .destination_ip  (destination_ip)
  );

  icmp_echo_checker chk0 (
    .rx_clock        (rx_clock),
    .arst_n          (arst_n),
    .rx_enable       (rx_enable),
    .rx_data         (rx_data),
    .tx_enable       (tx_enable),
    .remote_mac      (remote_mac),
    .remote_ip       (remote_ip),
    .dst_unreachable (dst_unreachable),
    .tx_request      (tx_request),
    .tx_active       (tx_active),
    .tx_data         (tx_data),
    .length          (length),
    .destination_mac (destination_mac),
    .destination_ip  (destination_ip),
    .errors          (check_errors),
    .messages        (message_count),
    .replies         (reply_count),
    .reply_pending   (reply_pending)
  );

  initial
  begin
    rx_clock = 1'b0;
    forever #10 rx_clock = ~rx_clock;
  end

  // one message cut after hdr_len bytes when the header is short
  task automatic send_message(input byte_t msg_type, input byte_t code, input int hdr_len,
                              input int pay_len);
    byte_t b;
    int    total;
    total = (hdr_len < int'(HEADER_LEN)) ? hdr_len : hdr_len + pay_len;
    for (int i = 0; i < total; i++)
    begin
      case (i)
        0:       b = msg_type;
        1:       b = code;
        default: b = 8'($urandom);
      endcase
      @(posedge rx_clock);
      rx_enable <= 1'b1;
      rx_data   <= b;
      // fresh addresses for the first byte and changed again right after
      if (i < 2)
      begin
        remote_mac <= {16'($urandom), $urandom};
        remote_ip  <= $urandom;
      end
    end
    @(posedge rx_clock);
    rx_enable <= 1'b0;
    rx_data   <= 8'd0;
    // let a reply request show up and wait out the reply
    repeat (2) @(posedge rx_clock);
    do
      @(negedge rx_clock);
    while (tx_request || tx_active);
    repeat ($urandom_range(1, 4)) @(posedge rx_clock);
  endtask

  task automatic run_random_messages();
    byte_t msg_type;
    byte_t code;
    int    pick;
    int    hdr_len;
    int    pay_len;
    for (int m = 0; m < RANDOM_MESSAGES; m++)
    begin
      pick = $urandom_range(0, 9);
      if (pick < 7)
        msg_type = ICMP_ECHO_REQUEST;
      else if (pick == 7)
        msg_type = ICMP_DST_UNREACHABLE;
      else
        msg_type = 8'($urandom_range(9, 255));
      code    = ($urandom_range(0, 9) == 0) ? 8'($urandom_range(1, 255)) : 8'd0;
      hdr_len = ($urandom_range(0, 9) == 0) ? int'($urandom_range(1, 3)) : 4;
      pay_len = $urandom_range(0, MAX_PAYLOAD);
      send_message(msg_type, code, hdr_len, pay_len);
    end
  endtask

  // empty, odd, edge of buffer, overflow and each drop reason
  task automatic run_directed_messages();
    send_message(ICMP_ECHO_REQUEST, 8'd0, 4, 0);
    send_message(ICMP_ECHO_REQUEST, 8'd0, 4, 1);
    send_message(ICMP_ECHO_REQUEST, 8'd0, 4, PAYLOAD_DEPTH - 1);
    send_message(ICMP_ECHO_REQUEST, 8'd0, 4, PAYLOAD_DEPTH);
    send_message(ICMP_ECHO_REQUEST, 8'd0, 4, PAYLOAD_DEPTH + 1);
    send_message(ICMP_ECHO_REQUEST, 8'h01, 4, 10);
    send_message(ICMP_ECHO_REQUEST, 8'd0, 2, 0);
    send_message(ICMP_DST_UNREACHABLE, 8'd0, 4, 8);
    send_message(8'd13, 8'd0, 4, 5);
  endtask

  // transmitter model granting one cycle after a random delay
  initial
  begin
    int delay;
    forever
    begin
      @(negedge rx_clock);
      if (tx_request && !tx_active)
      begin
        delay = $urandom_range(0, 5);
        repeat (delay + 1) @(posedge rx_clock);
        tx_enable <= 1'b1;
        @(posedge rx_clock);
        tx_enable <= 1'b0;
        do
          @(negedge rx_clock);
        while (tx_request);
      end
    end
  end

  // ------------------------------
  // cycle limit
  // ------------------------------
  initial
  begin
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge rx_clock);
      cycle_count++;
    end
    $display("run stopped after %0d cycles without finishing the stimulus", cycle_count);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    int end_errors;
    arst_n     = 1'b0;
    rx_enable  = 1'b0;
    rx_data    = 8'd0;
    tx_enable  = 1'b0;
    remote_mac = '0;
    remote_ip  = '0;
    end_errors = 0;
    void'($urandom(32'he92a_19b0));
    repeat (5) @(posedge rx_clock);
    arst_n <= 1'b1;
    repeat (2) @(posedge rx_clock);
    run_random_messages();
    run_directed_messages();
    repeat (10) @(posedge rx_clock);
    @(negedge rx_clock);
    if (reply_pending)
    begin
      $display("an echo request was never answered");
      end_errors = 1;
    end
    $display("summary: %0d messages, %0d replies, %0d checker errors, %0d end errors",
             message_count, reply_count, check_errors, end_errors);
    if (check_errors == 0 && end_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/icmp_pkg.sv
verilog/payload_fifo_if.sv
verilog/echo_reply_if.sv
verilog/icmp_rx_parser.sv
verilog/payload_buffer.sv
verilog/echo_tx_framer.sv
verilog/icmp_echo_top.sv
verif/icmp_echo_checker.sv
verif/tb_icmp_echo.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_icmp_echo -Mdir obj_dir -f project.f
	./obj_dir/Vtb_icmp_echo > sim.log 2>&1; cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
